// ==== run_sim.sh ====
#!/bin/sh
# Compile the testbench and the RTL with Verilator, then run the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_dmr_recovery -Mdir obj_dir \
  && ./obj_dir/Vtb_dmr_recovery \
  || { echo "Simulation did not pass"; exit 1; }

exit 0

// ==== sim.f ====
+incdir+verilog
verilog/recovery_pkg.sv
verilog/rf_address_generator.sv
verilog/dmr_recovery_controller.sv
verilog/recovery_regs.sv
verilog/dmr_recovery_top.sv
test/tb_dmr_recovery.sv

// ==== test/tb_dmr_recovery.sv ====
`timescale 1ns/1ns
`include "recovery_config.svh"

module tb_dmr_recovery
  import recovery_pkg::*;
();

  localparam int NUM_PAIRS  = `RECOVERY_NUM_GROUPS;
  localparam int SWEEP_LEN  = 1 << `RECOVERY_RF_ADDR_WIDTH;
  localparam int NUM_RECOV  = 40;
  localparam int MAX_LAT    = 8;
  // Each recovery is followed by up to a dozen APB accesses of three cycles
  localparam int APB_CYCLES = NUM_RECOV * 12 * 3 + 60;
  localparam int MAX_CYCLES = 2 * (NUM_RECOV * (30 + MAX_LAT) + APB_CYCLES);

  logic        clk_i = 1'b0;
  logic        rst_ni;
  apb_addr_t   paddr_i;
  logic        psel_i, penable_i, pwrite_i;
  apb_data_t   pwdata_i, prdata_o;
  logic        pready_o, pslverr_o;
  group_mask_t rf_err_i, core_err_i, debug_rsp_i;
  group_mask_t setback_o, instr_lock_o, clk_en_o, debug_req_o, debug_resume_o;
  group_mask_t pc_read_en_o, pc_write_en_o, recover_o, rf_we_a_o, rf_we_b_o;
  rf_addr_t    rf_waddr_a_o, rf_waddr_b_o;

  logic [31:0]     lcg_state = 32'hee41;
  int              cycle_cnt = 0;
  apb_data_t       exp_err_log = '0;
  recovery_count_t exp_count = '0;
  int              exp_last = 0;

  dmr_recovery_top UUT (.*);

  always #10 clk_i = ~clk_i;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "stopping at first error");
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > MAX_CYCLES) begin
      abort_run("Timeout: the run went past its cycle limit");
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 8;
  endfunction

  // Highest pair in error takes priority
  function automatic int highest_pair(input group_mask_t m);
    int h;
    h = 0;
    for (int i = 0; i < NUM_PAIRS; i++) begin
      if (m[i]) begin
        h = i;
      end
    end
    return h;
  endfunction

  task automatic check_mask(input string name, input group_mask_t got, input group_mask_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input rf_addr_t got, input rf_addr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input recovery_count_t got,
                             input recovery_count_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic tick();
    @(posedge clk_i);
    #2;
  endtask

  task automatic apb_access(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
    tick();
    paddr_i   = addr;
    pwrite_i  = wr;
    pwdata_i  = wdata;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    tick();
    penable_i = 1'b1;
    #1;
    if (pready_o !== 1'b1) begin
      abort_run("APB access phase saw pready low");
    end
    rdata = prdata_o;
    err   = pslverr_o;
    tick();
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_read_check(input apb_addr_t addr, input string name, input apb_data_t exp);
    apb_data_t rdata;
    logic      err;
    apb_access(addr, 1'b0, '0, rdata, err);
    if (err) begin
      abort_run($sformatf("APB read of mapped register %s returned pslverr", name));
    end
    check_data(name, rdata, exp);
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    apb_data_t rdata;
    logic      err;
    apb_access(addr, 1'b1, data, rdata, err);
    if (err) begin
      abort_run("APB write to a mapped register returned pslverr");
    end
  endtask

  task automatic check_quiet_outputs();
    check_mask("setback_o", setback_o, '0);
    check_mask("instr_lock_o", instr_lock_o, '0);
    check_mask("clk_en_o", clk_en_o, '1);
    check_mask("debug_req_o", debug_req_o, '0);
    check_mask("debug_resume_o", debug_resume_o, '0);
    check_mask("pc_read_en_o", pc_read_en_o, '0);
    check_mask("pc_write_en_o", pc_write_en_o, '1);
    check_mask("recover_o", recover_o, '0);
    check_mask("rf_we_a_o", rf_we_a_o, '0);
    check_mask("rf_we_b_o", rf_we_b_o, '0);
  endtask

  // The faulty pair is locked with PC writes off while all other pairs are clock gated
  task automatic check_frozen(input group_mask_t hot);
    check_mask("instr_lock_o", instr_lock_o, hot);
    check_mask("pc_write_en_o", pc_write_en_o, ~hot);
    check_mask("clk_en_o", clk_en_o, hot);
  endtask

  task automatic run_recovery(input group_mask_t rf_err, input group_mask_t core_err,
                              input int lat);
    group_mask_t hot;
    int          idx;
    idx = highest_pair(rf_err | core_err);
    hot = group_mask_t'(1) << idx;
    tick();
    rf_err_i    = rf_err;
    core_err_i  = core_err;
    exp_err_log = exp_err_log | apb_data_t'({core_err, rf_err});
    tick();
    rf_err_i   = '0;
    core_err_i = '0;
    #1;
    check_mask("setback_o", setback_o, hot);
    check_mask("debug_req_o", debug_req_o, '0);
    tick();
    #1;
    check_mask("setback_o", setback_o, '0);
    check_mask("debug_req_o", debug_req_o, hot);
    check_frozen(hot);
    // Core model acknowledges the halt after its latency
    for (int i = 1; i <= lat; i++) begin
      tick();
      if (i == lat) begin
        debug_rsp_i = hot;
      end
      #1;
      check_mask("debug_req_o", debug_req_o, '0);
      check_mask("pc_read_en_o", pc_read_en_o, '0);
      check_frozen(hot);
    end
    for (int i = 0; i < `RECOVERY_PC_CYCLES; i++) begin
      tick();
      debug_rsp_i = '0;
      #1;
      check_mask("pc_read_en_o", pc_read_en_o, hot);
      check_mask("rf_we_a_o", rf_we_a_o, '0);
      check_frozen(hot);
    end
    for (int j = 0; j < SWEEP_LEN; j++) begin
      tick();
      // STATUS is read in the first sweep cycles while the routine is still busy
      if (j == 0) begin
        paddr_i  = apb_addr_t'('h8);
        pwrite_i = 1'b0;
        psel_i   = 1'b1;
      end else if (j == 1) begin
        penable_i = 1'b1;
      end else if (j == 2) begin
        psel_i    = 1'b0;
        penable_i = 1'b0;
      end
      #1;
      if (j == 1) begin
        check_data("STATUS", prdata_o, (apb_data_t'(exp_last) << 8) | 32'h1);
      end
      check_mask("rf_we_a_o", rf_we_a_o, hot);
      check_mask("rf_we_b_o", rf_we_b_o, hot);
      check_addr("rf_waddr_a_o", rf_waddr_a_o, rf_addr_t'(j));
      check_addr("rf_waddr_b_o", rf_waddr_b_o, rf_addr_t'(j + SWEEP_LEN));
      check_mask("recover_o", recover_o, (j == 0) ? group_mask_t'(0) : hot);
      check_mask("debug_resume_o", debug_resume_o,
                 (j == SWEEP_LEN - 1) ? hot : group_mask_t'(0));
      check_mask("pc_read_en_o", pc_read_en_o, '0);
      check_mask("debug_req_o", debug_req_o, '0);
      check_frozen(hot);
    end
    tick();
    #1;
    check_mask("rf_we_a_o", rf_we_a_o, '0);
    check_mask("rf_we_b_o", rf_we_b_o, '0);
    check_mask("debug_resume_o", debug_resume_o, '0);
    check_mask("instr_lock_o", instr_lock_o, '0);
    check_mask("clk_en_o", clk_en_o, hot);
    check_mask("pc_write_en_o", pc_write_en_o, ~hot);
    tick();
    #1;
    check_quiet_outputs();
    exp_count = exp_count + 1'b1;
    exp_last  = idx;
  endtask

  task automatic check_regs();
    apb_data_t rdata;
    logic      err;
    apb_read_check(apb_addr_t'('h8), "STATUS", apb_data_t'(exp_last) << 8);
    apb_access(apb_addr_t'('hC), 1'b0, '0, rdata, err);
    if (err) begin
      abort_run("APB read of mapped register COUNT returned pslverr");
    end
    check_count("COUNT", recovery_count_t'(rdata[15:0]), exp_count);
    check_data("COUNT upper bits", rdata >> 16, '0);
    apb_read_check(apb_addr_t'('h4), "ERR_LOG", exp_err_log);
    apb_write(apb_addr_t'('h4), '1);
    exp_err_log = '0;
  endtask

  // Errors on pairs disabled in CTRL are logged but start no routine
  task automatic run_masked();
    group_mask_t m;
    int          p;
    m = group_mask_t'(lcg_next());
    p = int'(lcg_next() % NUM_PAIRS);
    m[p] = 1'b0;
    apb_write(apb_addr_t'('h0), apb_data_t'(m));
    apb_read_check(apb_addr_t'('h0), "CTRL", apb_data_t'(m));
    tick();
    rf_err_i[p]   = lcg_next() % 2 == 0;
    core_err_i[p] = !rf_err_i[p] || (lcg_next() % 2 == 0);
    exp_err_log = exp_err_log | apb_data_t'({core_err_i, rf_err_i});
    for (int i = 0; i < 4; i++) begin
      tick();
      rf_err_i   = '0;
      core_err_i = '0;
      #1;
      check_quiet_outputs();
    end
    apb_read_check(apb_addr_t'('h8), "STATUS", apb_data_t'(exp_last) << 8);
    apb_read_check(apb_addr_t'('h4), "ERR_LOG", exp_err_log);
    apb_write(apb_addr_t'('h4), '1);
    exp_err_log = '0;
    apb_read_check(apb_addr_t'('h4), "ERR_LOG", exp_err_log);
    apb_write(apb_addr_t'('h0), '1);
  endtask

  initial begin
    apb_data_t   rdata;
    logic        err;
    group_mask_t rf_m, core_m;
    int          idx, kind;
    rst_ni      = 1'b0;
    paddr_i     = '0;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    pwdata_i    = '0;
    rf_err_i    = '0;
    core_err_i  = '0;
    debug_rsp_i = '0;
    repeat (10) tick();
    rst_ni = 1'b1;
    tick();
    check_quiet_outputs();
    apb_read_check(apb_addr_t'('h0), "CTRL", apb_data_t'(group_mask_t'('1)));
    apb_read_check(apb_addr_t'('hC), "COUNT", '0);
    apb_read_check(apb_addr_t'('h4), "ERR_LOG", '0);
    apb_access(apb_addr_t'('h2), 1'b0, '0, rdata, err);
    if (err !== 1'b1) begin
      abort_run("Read of an unmapped address did not raise pslverr");
    end
    for (int r = 0; r < NUM_RECOV; r++) begin
      if (r % 4 == 3) begin
        run_masked();
      end
      if (lcg_next() % 3 == 0) begin
        rf_m   = group_mask_t'(lcg_next() % 15 + 1);
        core_m = group_mask_t'(lcg_next());
      end else begin
        idx    = int'(lcg_next() % NUM_PAIRS);
        kind   = int'(lcg_next() % 3);
        rf_m   = (kind != 1) ? group_mask_t'(1) << idx : group_mask_t'(0);
        core_m = (kind != 0) ? group_mask_t'(1) << idx : group_mask_t'(0);
      end
      run_recovery(rf_m, core_m, int'(lcg_next() % MAX_LAT) + 1);
      check_regs();
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== verilog/dmr_recovery_controller.sv ====
`timescale 1ns/1ns
`include "recovery_config.svh"

module dmr_recovery_controller
  import recovery_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  group_mask_t rf_err_i,
  input  group_mask_t core_err_i,
  input  group_mask_t group_mask_i,
  input  group_mask_t debug_rsp_i,
  output group_mask_t setback_o,
  output group_mask_t instr_lock_o,
  output group_mask_t clk_en_o,
  output group_mask_t debug_req_o,
  output group_mask_t debug_resume_o,
  output group_mask_t pc_read_en_o,
  output group_mask_t pc_write_en_o,
  output group_mask_t recover_o,
  output group_mask_t rf_we_a_o,
  output group_mask_t rf_we_b_o,
  output rf_addr_t    rf_waddr_a_o,
  output rf_addr_t    rf_waddr_b_o,
  output logic        busy_o,
  output group_idx_t  last_group_o,
  output logic        recovery_done_o
);

  localparam int unsigned PC_CNT_W = $clog2(`RECOVERY_PC_CYCLES + 1);
  localparam logic [PC_CNT_W-1:0] PC_CNT_LAST = PC_CNT_W'(`RECOVERY_PC_CYCLES - 1);

  recovery_state_e state_q, state_d;

  group_mask_t pending;
  logic        start;
  group_idx_t  err_idx_d, err_idx_q;
  group_idx_t  last_group_q;

  logic          clear;
  logic          sweep_en;
  rf_half_addr_t half_addr;
  logic          half_last;

  logic [PC_CNT_W-1:0] pc_cnt_d, pc_cnt_q;

  group_mask_t lock_d, lock_q;
  group_mask_t clk_en_d, clk_en_q;
  group_mask_t pc_we_d, pc_we_q;
  group_mask_t recover_d, recover_q;
  group_mask_t setback, debug_req, debug_resume, pc_read_en, rf_we;

  // Only pairs enabled in the mask may start a routine
  assign pending = (rf_err_i | core_err_i) & group_mask_i;
  assign start   = |pending;

  // Later iterations overwrite earlier ones, so the highest index wins
  always_comb begin
    err_idx_d = '0;
    for (int i = 0; i < `RECOVERY_NUM_GROUPS; i++) begin
      if (pending[i]) begin
        err_idx_d = group_idx_t'(i);
      end
    end
  end

  // The faulty pair is captured once in IDLE and held for the whole routine
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_idx_q <= '0;
    end else if (clear) begin
      err_idx_q <= '0;
    end else if (state_q == IDLE && start) begin
      err_idx_q <= err_idx_d;
    end
  end

  // Kept past EXIT so the register block can report it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_group_q <= '0;
    end else if (state_q == EXIT) begin
      last_group_q <= err_idx_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      pc_cnt_q <= '0;
      lock_q    <= '0;
      clk_en_q  <= '1;
      pc_we_q   <= '1;
      recover_q <= '0;
    end else begin
      state_q  <= state_d;
      pc_cnt_q <= pc_cnt_d;
      lock_q    <= lock_d;
      clk_en_q  <= clk_en_d;
      pc_we_q   <= pc_we_d;
      recover_q <= recover_d;
    end
  end

  always_comb begin
    state_d      = state_q;
    pc_cnt_d     = pc_cnt_q;
    lock_d       = lock_q;
    clk_en_d     = clk_en_q;
    pc_we_d      = pc_we_q;
    recover_d    = recover_q;
    clear        = 1'b0;
    sweep_en     = 1'b0;
    setback      = '0;
    debug_req    = '0;
    debug_resume = '0;
    pc_read_en   = '0;
    rf_we        = '0;
    case (state_q)
      IDLE: begin
        if (start) begin
          state_d = SETBACK;
        end
      end
      SETBACK: begin
        setback[err_idx_q] = 1'b1;
        lock_d[err_idx_q]  = 1'b1;
        pc_we_d[err_idx_q] = 1'b0;
        // Every other pair is frozen while this one recovers
        for (int i = 0; i < `RECOVERY_NUM_GROUPS; i++) begin
          if (group_idx_t'(i) != err_idx_q) begin
            clk_en_d[i] = 1'b0;
          end
        end
        state_d = HALT_REQ;
      end
      HALT_REQ: begin
        debug_req[err_idx_q] = 1'b1;
        state_d = HALT_WAIT;
      end
      HALT_WAIT: begin
        if (debug_rsp_i[err_idx_q]) begin
          state_d = RESTORE_PC;
        end
      end
      RESTORE_PC: begin
        pc_read_en[err_idx_q] = 1'b1;
        if (pc_cnt_q == PC_CNT_LAST) begin
          pc_cnt_d = '0;
          state_d  = RESTORE_RF;
        end else begin
          pc_cnt_d = pc_cnt_q + 1'b1;
        end
      end
      RESTORE_RF: begin
        sweep_en             = 1'b1;
        rf_we[err_idx_q]     = 1'b1;
        recover_d[err_idx_q] = 1'b1;
        if (half_last) begin
          lock_d[err_idx_q]       = 1'b0;
          debug_resume[err_idx_q] = 1'b1;
          state_d = EXIT;
        end
      end
      EXIT: begin
        // Return every per-pair register to its reset value
        clear     = 1'b1;
        pc_cnt_d  = '0;
        lock_d    = '0;
        clk_en_d  = '1;
        pc_we_d   = '1;
        recover_d = '0;
        state_d   = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  rf_address_generator u_rf_addr_gen (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear),
    .enable_i (sweep_en),
    .addr_o   (half_addr),
    .last_o   (half_last)
  );

  // Port a reloads the lower half and port b the upper half in the same cycle
  assign rf_waddr_a_o = {1'b0, half_addr};
  assign rf_waddr_b_o = {1'b1, half_addr};
  assign rf_we_a_o    = rf_we;
  assign rf_we_b_o    = rf_we;

  assign setback_o      = setback;
  assign debug_req_o    = debug_req;
  assign debug_resume_o = debug_resume;
  assign pc_read_en_o   = pc_read_en;
  assign instr_lock_o   = lock_q;
  assign clk_en_o       = clk_en_q;
  assign pc_write_en_o  = pc_we_q;
  assign recover_o      = recover_q;

  assign busy_o          = (state_q != IDLE);
  assign last_group_o    = last_group_q;
  assign recovery_done_o = (state_q == EXIT);

endmodule

// ==== verilog/dmr_recovery_top.sv ====
`timescale 1ns/1ns

module dmr_recovery_top
  import recovery_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  apb_addr_t   paddr_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  apb_data_t   pwdata_i,
  output apb_data_t   prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  input  group_mask_t rf_err_i,
  input  group_mask_t core_err_i,
  input  group_mask_t debug_rsp_i,
  output group_mask_t setback_o,
  output group_mask_t instr_lock_o,
  output group_mask_t clk_en_o,
  output group_mask_t debug_req_o,
  output group_mask_t debug_resume_o,
  output group_mask_t pc_read_en_o,
  output group_mask_t pc_write_en_o,
  output group_mask_t recover_o,
  output group_mask_t rf_we_a_o,
  output group_mask_t rf_we_b_o,
  output rf_addr_t    rf_waddr_a_o,
  output rf_addr_t    rf_waddr_b_o
);

  group_mask_t group_mask;
  logic        busy;
  group_idx_t  last_group;
  logic        recovery_done;

  recovery_regs u_regs (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .paddr_i         (paddr_i),
    .psel_i          (psel_i),
    .penable_i       (penable_i),
    .pwrite_i        (pwrite_i),
    .pwdata_i        (pwdata_i),
    .prdata_o        (prdata_o),
    .pready_o        (pready_o),
    .pslverr_o       (pslverr_o),
    .rf_err_i        (rf_err_i),
    .core_err_i      (core_err_i),
    .busy_i          (busy),
    .last_group_i    (last_group),
    .recovery_done_i (recovery_done),
    .group_mask_o    (group_mask)
  );

  dmr_recovery_controller u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rf_err_i        (rf_err_i),
    .core_err_i      (core_err_i),
    .group_mask_i    (group_mask),
    .debug_rsp_i     (debug_rsp_i),
    .setback_o       (setback_o),
    .instr_lock_o    (instr_lock_o),
    .clk_en_o        (clk_en_o),
    .debug_req_o     (debug_req_o),
    .debug_resume_o  (debug_resume_o),
    .pc_read_en_o    (pc_read_en_o),
    .pc_write_en_o   (pc_write_en_o),
    .recover_o       (recover_o),
    .rf_we_a_o       (rf_we_a_o),
    .rf_we_b_o       (rf_we_b_o),
    .rf_waddr_a_o    (rf_waddr_a_o),
    .rf_waddr_b_o    (rf_waddr_b_o),
    .busy_o          (busy),
    .last_group_o    (last_group),
    .recovery_done_o (recovery_done)
  );

endmodule

// ==== verilog/recovery_config.svh ====
`ifndef RECOVERY_CONFIG_SVH
`define RECOVERY_CONFIG_SVH

// Number of lock-stepped core pairs watched by the controller
`define RECOVERY_NUM_GROUPS 4

// Width of an address within one half of the register file
// A 32-entry register file is reloaded as two halves of 16 entries
`define RECOVERY_RF_ADDR_WIDTH 4

// Number of cycles the saved PC is read back before the register sweep
`define RECOVERY_PC_CYCLES 2

// Address width of the APB register block
`define RECOVERY_APB_ADDR_WIDTH 4

`endif

// ==== verilog/recovery_pkg.sv ====
`include "recovery_config.svh"

package recovery_pkg;

  typedef logic [`RECOVERY_NUM_GROUPS-1:0] group_mask_t;
  typedef logic [$clog2(`RECOVERY_NUM_GROUPS)-1:0] group_idx_t;

  // A full address carries the half select as its top bit
  typedef logic [`RECOVERY_RF_ADDR_WIDTH:0] rf_addr_t;
  typedef logic [`RECOVERY_RF_ADDR_WIDTH-1:0] rf_half_addr_t;

  typedef logic [15:0] recovery_count_t;

  typedef logic [`RECOVERY_APB_ADDR_WIDTH-1:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  typedef enum logic [2:0] {
    IDLE,
    SETBACK,
    HALT_REQ,
    HALT_WAIT,
    RESTORE_PC,
    RESTORE_RF,
    EXIT
  } recovery_state_e;

endpackage

// ==== verilog/recovery_regs.sv ====
`timescale 1ns/1ns
`include "recovery_config.svh"

module recovery_regs
  import recovery_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  apb_addr_t   paddr_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  apb_data_t   pwdata_i,
  output apb_data_t   prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  input  group_mask_t rf_err_i,
  input  group_mask_t core_err_i,
  input  logic        busy_i,
  input  group_idx_t  last_group_i,
  input  logic        recovery_done_i,
  output group_mask_t group_mask_o
);

  localparam int unsigned ERR_W = 2 * `RECOVERY_NUM_GROUPS;

  localparam apb_addr_t ADDR_CTRL    = apb_addr_t'('h0);
  localparam apb_addr_t ADDR_ERR_LOG = apb_addr_t'('h4);
  localparam apb_addr_t ADDR_STATUS  = apb_addr_t'('h8);
  localparam apb_addr_t ADDR_COUNT   = apb_addr_t'('hC);

  logic access, wr_en, rd_en;
  logic sel_ctrl, sel_err, sel_status, sel_count, mapped;

  group_mask_t     mask_q;
  logic [ERR_W-1:0] err_log_q;
  logic [ERR_W-1:0] err_clr;
  recovery_count_t count_q;
  apb_data_t       status_word;

  // Every access completes in its first access-phase cycle
  assign access   = psel_i & penable_i;
  assign wr_en    = access & pwrite_i;
  assign rd_en    = access & ~pwrite_i;
  assign pready_o = 1'b1;

  assign sel_ctrl   = (paddr_i == ADDR_CTRL);
  assign sel_err    = (paddr_i == ADDR_ERR_LOG);
  assign sel_status = (paddr_i == ADDR_STATUS);
  assign sel_count  = (paddr_i == ADDR_COUNT);
  assign mapped     = sel_ctrl | sel_err | sel_status | sel_count;

  assign pslverr_o = access & ~mapped;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q <= '1;
    end else if (wr_en && sel_ctrl) begin
      mask_q <= pwdata_i[`RECOVERY_NUM_GROUPS-1:0];
    end
  end

  assign err_clr = (wr_en && sel_err) ? pwdata_i[ERR_W-1:0] : '0;

  // A new error in the same cycle as a clear stays logged
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_log_q <= '0;
    end else begin
      err_log_q <= (err_log_q & ~err_clr) | {core_err_i, rf_err_i};
    end
  end

  // Completed routines, held at the top value instead of wrapping
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (recovery_done_i && (count_q != '1)) begin
      count_q <= count_q + 1'b1;
    end
  end

  always_comb begin
    status_word = '0;
    status_word[0] = busy_i;
    status_word[8 +: $bits(group_idx_t)] = last_group_i;
  end

  always_comb begin
    prdata_o = '0;
    if (rd_en) begin
      if (sel_ctrl) begin
        prdata_o = apb_data_t'(mask_q);
      end else if (sel_err) begin
        prdata_o = apb_data_t'(err_log_q);
      end else if (sel_status) begin
        prdata_o = status_word;
      end else if (sel_count) begin
        prdata_o = apb_data_t'(count_q);
      end
    end
  end

  assign group_mask_o = mask_q;

endmodule

// ==== verilog/rf_address_generator.sv ====
`timescale 1ns/1ns

module rf_address_generator
  import recovery_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear_i,
  input  logic          enable_i,
  output rf_half_addr_t addr_o,
  output logic          last_o
);

  rf_half_addr_t addr_q;

  // Sweep counter over one half of the register file
  // Clear takes priority so a new routine always starts at address zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (clear_i) begin
      addr_q <= '0;
    end else if (enable_i) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  assign addr_o = addr_q;

  // The top address of the half range ends the sweep
  assign last_o = (addr_q == '1);

endmodule
